// File: dram_ecc.f
verilog/dram_ecc_pkg.sv
verilog/dram_ecc_gen.sv
verilog/dram_ecc_syndrome.sv
verilog/dram_ecc_decode.sv
verilog/dram_ecc_correct.sv
verilog/dram_ecc_cor.sv
testbench/tb_clock.sv
testbench/dram_ecc_sva.sv
testbench/dram_ecc_tb.sv

// File: testbench/dram_ecc_sva.sv
////////////////////
// Concurrent checks on the corrector outputs
// Bound into the top level
////////////////////
`timescale 1ns/1ps

module dram_ecc_sva (
   input logic               clk,
   input logic               rst,
   input dram_ecc_pkg::loc_t ecc_loc,
   input logic               single_err,
   input logic               multi_err
);

   // Number of assertion failures so far
   int fail_count = 0;

   flags_excl: assert property (@(posedge clk) disable iff (rst)
      !(single_err && multi_err))
      else begin
         $error("single_err and multi_err high together");
         fail_count++;
      end

   loc_onehot: assert property (@(posedge clk) disable iff (rst)
      $onehot0(ecc_loc))
      else begin
         $error("ecc_loc has more than one bit set");
         fail_count++;
      end

   // A multiple error carries no location
   loc_multi: assert property (@(posedge clk) disable iff (rst)
      multi_err |-> (ecc_loc == '0))
      else begin
         $error("ecc_loc set while multi_err is high");
         fail_count++;
      end

   loc_single: assert property (@(posedge clk) disable iff (rst)
      (ecc_loc != '0) == single_err)
      else begin
         $error("ecc_loc and single_err disagree");
         fail_count++;
      end

   // One edge in reset clears the output register
   rst_quiet: assert property (@(posedge clk)
      rst |=> (!single_err && !multi_err && ecc_loc == '0))
      else begin
         $error("outputs active during reset");
         fail_count++;
      end

endmodule

bind dram_ecc_cor dram_ecc_sva u_sva (
   .clk        (clk),
   .rst        (rst),
   .ecc_loc    (ecc_loc),
   .single_err (single_err),
   .multi_err  (multi_err)
);

// File: testbench/dram_ecc_tb.sv
////////////////////
// Testbench for the nibble ECC corrector
// Reference encoder, expected-value pipeline and checks
////////////////////
`timescale 1ns/1ps

module dram_ecc_tb;
   import dram_ecc_pkg::*;

   // 15 reset words, 416 test words, 2 drain cycles and margin
   localparam int max_cycles = 500;

   typedef struct packed {
      data_t data;
      loc_t  loc;
      logic  single;
      logic  multi;
   } expect_t;

   logic    clk;
   logic    rst;
   data_t   raw_data;
   ecc_t    raw_ecc;
   data_t   cor_data;
   loc_t    ecc_loc;
   logic    single_err;
   logic    multi_err;
   expect_t pipe_q [$];
   int      cycles = 0;

   tb_clock u_clock (.clk (clk));

   dram_ecc_cor uut (
      .clk        (clk),
      .rst        (rst),
      .raw_data   (raw_data),
      .raw_ecc    (raw_ecc),
      .cor_data   (cor_data),
      .ecc_loc    (ecc_loc),
      .single_err (single_err),
      .multi_err  (multi_err)
   );

   ////////////////////
   // Reference model
   ////////////////////

   // Multiply by alpha n times, x^4 = x + 1
   function automatic nib_t alpha_times(input nib_t a, input int n);
      nib_t r;
      int   i;
      r = a;
      for (i = 0; i < n; i++) begin
         r = {r[2:0], 1'b0} ^ (r[3] ? 4'h3 : 4'h0);
      end
      return r;
   endfunction

   function automatic ecc_t encode(input data_t d);
      nib_t c0;
      nib_t c1;
      nib_t c2;
      nib_t c3;
      nib_t lo;
      nib_t hi;
      int   k;
      c0 = d[124 +: 4];
      c1 = d[120 +: 4] ^ d[124 +: 4];
      c2 = c1;
      c3 = '0;
      for (k = 0; k < 15; k++) begin
         lo = d[4*k +: 4];
         hi = d[4*(15+k) +: 4];
         c0 = c0 ^ alpha_times(lo, k) ^ alpha_times(hi, k);
         c1 = c1 ^ lo;
         c2 = c2 ^ hi;
         c3 = c3 ^ alpha_times(lo, 2*k) ^ alpha_times(hi, 2*k);
      end
      return {c3, c2, c1, c0};
   endfunction

   // A lone error e in nibble i gives the encoding of e at i,
   // and e shows up unchanged in the parity nibble of its group
   function automatic expect_t predict(input data_t d, input ecc_t e);
      expect_t    x;
      ecc_t       syn;
      nib_t       sym;
      logic [3:0] nz;
      int         i;
      syn = encode(d) ^ e;
      nz = {|syn[15:12], |syn[11:8], |syn[7:4], |syn[3:0]};
      x = '0;
      x.data = d;
      if ($onehot(nz)) begin
         x.loc[n_data_nib +: n_chk_nib] = nz;
         x.single = 1'b1;
      end else if (nz != 4'h0) begin
         for (i = 0; i < n_data_nib; i++) begin
            sym = (i >= 15 && i < 30) ? syn[11:8] : syn[7:4];
            if (sym != 4'h0 && encode(data_t'(sym) << (nib_w*i)) == syn) begin
               x.loc[i] = 1'b1;
               x.data[nib_w*i +: nib_w] = d[nib_w*i +: nib_w] ^ sym;
               x.single = 1'b1;
            end
         end
         x.multi = !x.single;
      end
      return x;
   endfunction

   ////////////////////
   // Checks
   ////////////////////

   task automatic report_mismatch(input string name, input data_t got, input data_t exp);
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic report_failure(input string what);
      $display("%0t ns: %s", $time, what);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic check_head();
      expect_t x;
      x = pipe_q.pop_front();
      assert (uut.u_sva.fail_count == 0)
         else report_failure("a bound assertion on the DUT outputs failed");
      assert (cor_data === x.data)
         else report_mismatch("cor_data", cor_data, x.data);
      assert (ecc_loc === x.loc)
         else report_mismatch("ecc_loc", data_t'(ecc_loc), data_t'(x.loc));
      assert (single_err === x.single)
         else report_mismatch("single_err", data_t'(single_err), data_t'(x.single));
      assert (multi_err === x.multi)
         else report_mismatch("multi_err", data_t'(multi_err), data_t'(x.multi));
   endtask

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= max_cycles) begin
         $display("Timeout: run passed %0d cycles without finishing", max_cycles);
         $display("Done: errors found");
         $fatal(1);
      end
   end

   ////////////////////
   // Stimulus
   ////////////////////

   function automatic data_t random_word();
      return {$urandom, $urandom, $urandom, $urandom};
   endfunction

   function automatic nib_t nonzero_nib();
      return nib_t'($urandom_range(15, 1));
   endfunction

   function automatic data_t flip_nibble(input data_t d, input int idx, input nib_t pat);
      return d ^ (data_t'(pat) << (nib_w*idx));
   endfunction

   // Outputs seen at a falling edge belong to the word driven two falling edges before
   task automatic drive_word(input logic rst_val, input data_t d, input ecc_t e);
      @(negedge clk);
      if (pipe_q.size() == 2) begin
         check_head();
      end
      rst      = rst_val;
      raw_data = d;
      raw_ecc  = e;
      pipe_q.push_back(rst_val ? expect_t'('0) : predict(d, e));
   endtask

   // Kind 0 clean, 1 data nibble, 2 check nibble, 3 two data nibbles
   task automatic drive_case(input int kind, input int idx);
      data_t d;
      data_t bad;
      ecc_t  e;
      int    other;
      d = random_word();
      bad = d;
      e = encode(d);
      other = (idx + $urandom_range(31, 1)) % n_data_nib;
      case (kind)
         1: bad = flip_nibble(d, idx, nonzero_nib());
         2: e = e ^ (ecc_t'(nonzero_nib()) << (nib_w*(idx % n_chk_nib)));
         3: bad = flip_nibble(flip_nibble(d, idx, nonzero_nib()), other, nonzero_nib());
         default: bad = d;
      endcase
      drive_word(1'b0, bad, e);
   endtask

   initial begin
      data_t d;
      int    i;
      rst      = 1'b1;
      raw_data = '0;
      raw_ecc  = '0;
      void'($urandom(32'h0356_54d2));

      // Reset held over 16 rising edges, inputs keep moving
      repeat (15) begin
         d = random_word();
         drive_word(1'b1, d, encode(d));
      end

      repeat (80) drive_case(0, 0);
      for (i = 0; i < n_data_nib; i++) begin
         repeat (3) drive_case(1, i);
      end
      for (i = 0; i < n_chk_nib; i++) begin
         repeat (5) drive_case(2, i);
      end
      repeat (180) drive_case(3, $urandom_range(31, 0));
      // Mixed back-to-back traffic
      repeat (40) drive_case($urandom_range(3, 0), $urandom_range(31, 0));

      repeat (2) begin
         @(negedge clk);
         check_head();
      end
      $display("Done: no errors");
      $finish;
   end

endmodule

// File: testbench/tb_clock.sv
////////////////////
// Testbench clock, 100 ns period
////////////////////
`timescale 1ns/1ps

module tb_clock (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   always #50 clk = ~clk;

endmodule

// File: verilog/dram_ecc_cor.sv
////////////////////
// Top level of the two-stage ECC checker and corrector
////////////////////
`timescale 1ns/1ps

module dram_ecc_cor (
   input  logic                clk,
   input  logic                rst,
   input  dram_ecc_pkg::data_t raw_data,
   input  dram_ecc_pkg::ecc_t  raw_ecc,
   output dram_ecc_pkg::data_t cor_data,
   output dram_ecc_pkg::loc_t  ecc_loc,
   output logic                single_err,
   output logic                multi_err
);
   import dram_ecc_pkg::*;

   ecc_t  syndrome;
   data_t data_d1;
   loc_t  err_loc;
   nib_t  err_sym;
   logic  single;
   logic  multi;

   // Stage 1
   dram_ecc_syndrome u_syndrome (
      .clk      (clk),
      .rst      (rst),
      .raw_data (raw_data),
      .raw_ecc  (raw_ecc),
      .syndrome (syndrome),
      .data_d1  (data_d1)
   );

   dram_ecc_decode u_decode (
      .syndrome (syndrome),
      .err_loc  (err_loc),
      .err_sym  (err_sym),
      .single   (single),
      .multi    (multi)
   );

   // Stage 2
   dram_ecc_correct u_correct (
      .clk        (clk),
      .rst        (rst),
      .data_d1    (data_d1),
      .err_loc    (err_loc),
      .err_sym    (err_sym),
      .single     (single),
      .multi      (multi),
      .cor_data   (cor_data),
      .ecc_loc    (ecc_loc),
      .single_err (single_err),
      .multi_err  (multi_err)
   );

endmodule

// File: verilog/dram_ecc_correct.sv
////////////////////
// Nibble correction and output register
////////////////////
`timescale 1ns/1ps

module dram_ecc_correct (
   input  logic                clk,
   input  logic                rst,
   input  dram_ecc_pkg::data_t data_d1,
   input  dram_ecc_pkg::loc_t  err_loc,
   input  dram_ecc_pkg::nib_t  err_sym,
   input  logic                single,
   input  logic                multi,
   output dram_ecc_pkg::data_t cor_data,
   output dram_ecc_pkg::loc_t  ecc_loc,
   output logic                single_err,
   output logic                multi_err
);
   import dram_ecc_pkg::*;

   data_t fixed_data;

   // At most one location bit is set, multi leaves them all clear
   for (genvar i = 0; i < n_data_nib; i++) begin : g_fix
      assign fixed_data[nib_w*i +: nib_w] =
         data_d1[nib_w*i +: nib_w] ^ (err_loc[i] ? err_sym : nib_t'(0));
   end

   ////////////////////
   // Result register
   ////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         cor_data   <= '0;
         ecc_loc    <= '0;
         single_err <= 1'b0;
         multi_err  <= 1'b0;
      end else begin
         cor_data   <= fixed_data;
         ecc_loc    <= err_loc;
         single_err <= single;
         multi_err  <= multi;
      end
   end

endmodule

// File: verilog/dram_ecc_decode.sv
////////////////////
// Syndrome decoder, locates the failing symbol and
// classifies single or multiple errors
////////////////////
`timescale 1ns/1ps

module dram_ecc_decode (
   input  dram_ecc_pkg::ecc_t syndrome,
   output dram_ecc_pkg::loc_t err_loc,
   output dram_ecc_pkg::nib_t err_sym,
   output logic               single,
   output logic               multi
);
   import dram_ecc_pkg::*;

   nib_t s0;
   nib_t s1;
   nib_t s2;
   nib_t s3;

   logic [n_chk_nib-1:0] nz;
   logic [n_grp_nib-1:0] lo_hit;
   logic [n_grp_nib-1:0] hi_hit;

   logic lo_err;
   logic hi_err;
   logic n30_err;
   logic n31_err;

   assign s0 = syndrome[0*nib_w +: nib_w];
   assign s1 = syndrome[1*nib_w +: nib_w];
   assign s2 = syndrome[2*nib_w +: nib_w];
   assign s3 = syndrome[3*nib_w +: nib_w];

   assign nz = {|s3, |s2, |s1, |s0};

   ////////////////////
   // Group matches
   ////////////////////

   // Lower group, nibble k gives s0 = a^k*s1 and s3 = a^2k*s1
   for (genvar k = 0; k < n_grp_nib; k++) begin : g_lo
      localparam nib_t w1 = gf_pow(k);
      localparam nib_t w2 = gf_pow(2 * k);

      assign lo_hit[k] = (s0 == gf_mul(w1, s1)) && (s3 == gf_mul(w2, s1));
   end

   // Upper group, same weights against s2
   for (genvar k = 0; k < n_grp_nib; k++) begin : g_hi
      localparam nib_t w1 = gf_pow(k);
      localparam nib_t w2 = gf_pow(2 * k);

      assign hi_hit[k] = (s0 == gf_mul(w1, s2)) && (s3 == gf_mul(w2, s2));
   end

   // Powers of alpha are distinct, so at most one hit per group
   assign lo_err  = nz[1] && !nz[2] && (|lo_hit);
   assign hi_err  = nz[2] && !nz[1] && (|hi_hit);
   assign n30_err = !nz[0] && !nz[3] && nz[1] && (s1 == s2);
   assign n31_err = nz[0] && !nz[3] && (s0 == s1) && (s1 == s2);

   ////////////////////
   // Classification
   ////////////////////

   always_comb begin
      err_loc = '0;
      err_sym = '0;
      single  = 1'b0;
      multi   = 1'b0;
      if ($onehot(nz)) begin
         // Lone check nibble hit, data is fine
         err_loc[n_data_nib +: n_chk_nib] = nz;
         single = 1'b1;
      end else if (lo_err) begin
         err_loc[0 +: n_grp_nib] = lo_hit;
         err_sym = s1;
         single  = 1'b1;
      end else if (hi_err) begin
         err_loc[n_grp_nib +: n_grp_nib] = hi_hit;
         err_sym = s2;
         single  = 1'b1;
      end else if (n30_err) begin
         err_loc[n_data_nib-2] = 1'b1;
         err_sym = s1;
         single  = 1'b1;
      end else if (n31_err) begin
         err_loc[n_data_nib-1] = 1'b1;
         err_sym = s1;
         single  = 1'b1;
      end else if (|nz) begin
         multi = 1'b1;   // no single symbol explains it
      end
   end

endmodule

// File: verilog/dram_ecc_gen.sv
////////////////////
// Check nibble generator, pure XOR network
////////////////////
`timescale 1ns/1ps

module dram_ecc_gen (
   input  dram_ecc_pkg::data_t data,
   output dram_ecc_pkg::ecc_t  ecc
);
   import dram_ecc_pkg::*;

   // Weighted data nibbles for c0 (alpha^k) and c3 (alpha^2k)
   wire nib_t t0_lo [n_grp_nib];
   wire nib_t t0_hi [n_grp_nib];
   wire nib_t t3_lo [n_grp_nib];
   wire nib_t t3_hi [n_grp_nib];

   nib_t d30;
   nib_t d31;
   nib_t c0;
   nib_t c1;
   nib_t c2;
   nib_t c3;

   assign d30 = data[nib_w*(n_data_nib-2) +: nib_w];
   assign d31 = data[nib_w*(n_data_nib-1) +: nib_w];

   for (genvar k = 0; k < n_grp_nib; k++) begin : g_term
      localparam nib_t w1 = gf_pow(k);
      localparam nib_t w2 = gf_pow(2 * k);

      assign t0_lo[k] = gf_mul(w1, data[nib_w*k +: nib_w]);
      assign t0_hi[k] = gf_mul(w1, data[nib_w*(n_grp_nib+k) +: nib_w]);
      assign t3_lo[k] = gf_mul(w2, data[nib_w*k +: nib_w]);
      assign t3_hi[k] = gf_mul(w2, data[nib_w*(n_grp_nib+k) +: nib_w]);
   end

   // Nibble 31 hits c0..c2, nibble 30 only the two parity nibbles
   always_comb begin
      c0 = d31;
      c1 = d30 ^ d31;
      c2 = d30 ^ d31;
      c3 = '0;
      for (int k = 0; k < n_grp_nib; k++) begin
         c0 = c0 ^ t0_lo[k] ^ t0_hi[k];
         c1 = c1 ^ data[nib_w*k +: nib_w];
         c2 = c2 ^ data[nib_w*(n_grp_nib+k) +: nib_w];
         c3 = c3 ^ t3_lo[k] ^ t3_hi[k];
      end
   end

   assign ecc = {c3, c2, c1, c0};

endmodule

// File: verilog/dram_ecc_pkg.sv
////////////////////
// Shared widths and vector types for the nibble ECC path
// GF(16) power table and symbol multiply
////////////////////
package dram_ecc_pkg;

   // Word geometry
   parameter int data_w     = 128;
   parameter int nib_w      = 4;
   parameter int n_data_nib = 32;
   parameter int n_chk_nib  = 4;
   parameter int n_loc      = n_data_nib + n_chk_nib;

   // Nibbles per check group, 0-14 and 15-29
   parameter int n_grp_nib  = 15;

   typedef logic [data_w-1:0]          data_t;
   typedef logic [n_chk_nib*nib_w-1:0] ecc_t;
   typedef logic [nib_w-1:0]           nib_t;
   typedef logic [n_loc-1:0]           loc_t;

   ////////////////////
   // GF(16) arithmetic
   ////////////////////

   // Field polynomial x^4 + x + 1, so x^4 folds back to 4'h3
   function automatic nib_t gf_xtime(input nib_t a);
      nib_t r;
      r = {a[2:0], 1'b0};
      if (a[3]) begin
         r = r ^ 4'h3;
      end
      return r;
   endfunction

   // alpha^p with alpha = 2, exponent taken mod 15
   function automatic nib_t gf_pow(input int p);
      nib_t r;
      int   n;
      int   i;
      r = 4'h1;
      n = p % 15;
      for (i = 0; i < n; i++) begin
         r = gf_xtime(r);
      end
      return r;
   endfunction

   // Shift and add multiply, one partial product per bit of b
   function automatic nib_t gf_mul(input nib_t a, input nib_t b);
      nib_t r;
      nib_t t;
      int   i;
      r = '0;
      t = a;
      for (i = 0; i < nib_w; i++) begin
         if (b[i]) begin
            r = r ^ t;
         end
         t = gf_xtime(t);
      end
      return r;
   endfunction

endpackage

// File: verilog/dram_ecc_syndrome.sv
////////////////////
// First pipeline stage
// Regenerates check bits and registers syndrome with data
////////////////////
`timescale 1ns/1ps

module dram_ecc_syndrome (
   input  logic                clk,
   input  logic                rst,
   input  dram_ecc_pkg::data_t raw_data,
   input  dram_ecc_pkg::ecc_t  raw_ecc,
   output dram_ecc_pkg::ecc_t  syndrome,
   output dram_ecc_pkg::data_t data_d1
);
   import dram_ecc_pkg::*;

   ecc_t gen_ecc;
   ecc_t diff_ecc;

   dram_ecc_gen u_gen (
      .data (raw_data),
      .ecc  (gen_ecc)
   );

   // Nonzero nibble means that check group disagrees
   assign diff_ecc = gen_ecc ^ raw_ecc;

   ////////////////////
   // Stage register
   ////////////////////

   // Data clears too, so the first word after reset reads as zero
   always_ff @(posedge clk) begin
      if (rst) begin
         syndrome <= '0;
         data_d1  <= '0;
      end else begin
         syndrome <= diff_ecc;
         data_d1  <= raw_data;
      end
   end

endmodule
